// ==== files.f ====
ring_pkg.sv
ring_msg_queue.sv
ring_arbiter.sv
ring_router.sv
ring_net.sv
ring_checker.sv
ring_tb.sv

// ==== ring_arbiter.sv ====
// round-robin arbiter for the clockwise output of a router
// through-traffic needs one credit, injection needs two (bubble rule)

module ring_arbiter
(
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  ring_req,
  input  logic                  inject_req,
  input  ring_pkg::credit_cnt_t ring_credit,
  output logic                  ring_gnt,
  output logic                  inject_gnt
);

  import ring_pkg::*;

  arb_state_t last_q;
  logic       ring_ok;
  logic       inject_ok;

  // qualified requests
  assign ring_ok   = ring_req && (ring_credit >= credit_cnt_t'(1));
  // keep one slot free downstream so the ring always drains
  assign inject_ok = inject_req && (ring_credit >= credit_cnt_t'(2));

  always_comb
  begin
    ring_gnt   = 1'b0;
    inject_gnt = 1'b0;
    if (ring_ok && inject_ok)
    begin
      // both qualify, take the one not served last
      if (last_q == last_ring)
        inject_gnt = 1'b1;
      else
        ring_gnt = 1'b1;
    end
    else
    begin
      ring_gnt   = ring_ok;
      inject_gnt = inject_ok;
    end
  end

  always_ff @(posedge clk)
  begin
    if (reset)
      last_q <= last_inject;
    else if (ring_gnt)
      last_q <= last_ring;
    else if (inject_gnt)
      last_q <= last_inject;
  end

  a_one_grant: assert property (@(posedge clk) disable iff (reset)
    !(ring_gnt && inject_gnt));

endmodule

// ==== ring_checker.sv ====
// scoreboard for the ring network
// learns messages at the injection ports, compares ejections per (dest, src) pair
// also guards idle outputs after reset and both credit loops

module ring_checker
#(
  parameter int p_num_nodes   = 8,
  parameter int p_queue_depth = 4
)
(
  input  logic                                 clk,
  input  logic                                 reset,
  input  logic                                 inject_started,
  input  logic                                 end_of_test,
  input  logic [p_num_nodes-1:0]               in_val,
  input  ring_pkg::net_msg_t [p_num_nodes-1:0] in_msg,
  input  logic [p_num_nodes-1:0]               in_credit,
  input  logic [p_num_nodes-1:0]               out_val,
  input  ring_pkg::net_msg_t [p_num_nodes-1:0] out_msg,
  input  logic [p_num_nodes-1:0]               sink_empty,
  output int                                   error_count,
  output int                                   pending,
  output int                                   delivered
);

  import ring_pkg::*;

  // node ids are 3 bits wide
  localparam int c_id_nbits = 3;
  localparam int c_num_keys = 1 << (2 * c_id_nbits);
  // dest in the top bits, src right below
  localparam int c_msg_top  = $bits(net_msg_t) - 1;

  // one queue per (dest, src) pair in injection order
  net_msg_t sb_q [c_num_keys][$];
  // source credits as seen on the ports
  int       src_cr [p_num_nodes];

  function automatic int dest_of(input net_msg_t msg);
    return int'(msg[c_msg_top -: c_id_nbits]);
  endfunction

  function automatic int src_of(input net_msg_t msg);
    return int'(msg[c_msg_top-c_id_nbits -: c_id_nbits]);
  endfunction

  function automatic int pair_key(input net_msg_t msg);
    return (dest_of(msg) << c_id_nbits) + src_of(msg);
  endfunction

  always @(posedge clk)
  begin
    net_msg_t exp_msg;
    int       key;
    int       dest;
    if (reset)
    begin
      error_count = 0;
      pending     = 0;
      delivered   = 0;
      for (int i = 0; i < p_num_nodes; i++)
        src_cr[i] = p_queue_depth;
    end
    else
    begin
      // -------------------- idle after reset
      if (!inject_started && ((out_val != '0) || (in_credit != '0)))
      begin
        $display("ERROR: out_val=%h in_credit=%h before any injection", out_val, in_credit);
        error_count++;
      end
      for (int i = 0; i < p_num_nodes; i++)
      begin
        // -------------------- expected side
        if (in_val[i])
        begin
          sb_q[pair_key(in_msg[i])].push_back(in_msg[i]);
          pending++;
          src_cr[i]--;
        end
        if (in_credit[i])
        begin
          src_cr[i]++;
          if (src_cr[i] > p_queue_depth)
          begin
            $display("ERROR: in_credit[%0d] raises source credits to %h, depth %h",
                     i, src_cr[i], p_queue_depth);
            error_count++;
          end
        end
        // -------------------- delivery side
        if (out_val[i])
        begin
          delivered++;
          dest = dest_of(out_msg[i]);
          // sink had no room left
          if (sink_empty[i])
          begin
            $display("ERROR: out_val[%0d]=%h while sink credits=%h", i, out_val[i], 0);
            error_count++;
          end
          if (dest != i)
          begin
            $display("ERROR: out_msg[%0d]=%h has dest %h", i, out_msg[i], dest);
            error_count++;
          end
          key = pair_key(out_msg[i]);
          if (sb_q[key].size() == 0)
          begin
            $display("ERROR: out_msg[%0d]=%h was never injected", i, out_msg[i]);
            error_count++;
          end
          else
          begin
            exp_msg = sb_q[key].pop_front();
            pending--;
            if (exp_msg != out_msg[i])
            begin
              $display("ERROR: out_msg[%0d]=%h expected=%h", i, out_msg[i], exp_msg);
              error_count++;
            end
          end
        end
      end
      // anything still queued was lost
      if (end_of_test)
      begin
        for (int k = 0; k < c_num_keys; k++)
        begin
          while (sb_q[k].size() != 0)
          begin
            exp_msg = sb_q[k].pop_front();
            $display("message %h was never delivered", exp_msg);
            error_count++;
          end
        end
      end
    end
  end

endmodule

// ==== ring_msg_queue.sv ====
// message FIFO for one router input
// circular buffer that pulses a credit back upstream after every pop

module ring_msg_queue
#(
  parameter int p_queue_depth = 4
)
(
  input  logic               clk,
  input  logic               reset,
  input  logic               push,
  input  ring_pkg::net_msg_t push_msg,
  input  logic               pop,
  output logic               head_val,
  output ring_pkg::net_msg_t head_msg,
  output logic               credit
);

  import ring_pkg::*;

  // pointer width, at least one bit
  localparam int c_ptr_nbits = (p_queue_depth > 1) ? $clog2(p_queue_depth) : 1;
  localparam logic [c_ptr_nbits-1:0] c_last_ptr = c_ptr_nbits'(p_queue_depth - 1);

  net_msg_t               mem [p_queue_depth];
  logic [c_ptr_nbits-1:0] wr_ptr;
  logic [c_ptr_nbits-1:0] rd_ptr;
  credit_cnt_t            count;
  logic                   full;

  // --------------------
  // storage
  // --------------------

  always_ff @(posedge clk)
  begin
    if (push)
      mem[wr_ptr] <= push_msg;
  end

  // head is whatever sits at the read pointer
  assign head_msg = mem[rd_ptr];
  assign head_val = (count != '0);
  assign full     = (count == credit_cnt_t'(p_queue_depth));

  // --------------------
  // pointers, count, credit
  // --------------------

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
      credit <= 1'b0;
    end
    else
    begin
      // wrap by hand, depth need not be a power of two
      if (push)
        wr_ptr <= (wr_ptr == c_last_ptr) ? '0 : wr_ptr + 1'b1;
      if (pop)
        rd_ptr <= (rd_ptr == c_last_ptr) ? '0 : rd_ptr + 1'b1;
      count  <= count + credit_cnt_t'(push) - credit_cnt_t'(pop);
      // one slot freed, tell the upstream sender next cycle
      credit <= pop;
    end
  end

  // upstream credit counter must never let a push into a full queue
  a_no_overflow: assert property (@(posedge clk) disable iff (reset)
    !(push && full && !pop));

  // router may only pop a valid head
  a_no_underflow: assert property (@(posedge clk) disable iff (reset)
    !(pop && !head_val));

endmodule

// ==== ring_net.sv ====
// top level of the unidirectional ring network
// p_num_nodes routers, router i feeds router (i+1) mod p_num_nodes

module ring_net
#(
  parameter int p_num_nodes   = 8,
  parameter int p_queue_depth = 4
)
(
  input  logic                                 clk,
  input  logic                                 reset,
  // injection ports
  input  logic [p_num_nodes-1:0]               in_val,
  input  ring_pkg::net_msg_t [p_num_nodes-1:0] in_msg,
  output logic [p_num_nodes-1:0]               in_credit,
  // ejection ports
  output logic [p_num_nodes-1:0]               out_val,
  output ring_pkg::net_msg_t [p_num_nodes-1:0] out_msg,
  input  logic [p_num_nodes-1:0]               out_credit
);

  import ring_pkg::*;

  // link i runs from router i to router i+1
  // link_credit[i] is returned by router i+1
  logic [p_num_nodes-1:0]     link_val;
  net_msg_t [p_num_nodes-1:0] link_msg;
  logic [p_num_nodes-1:0]     link_credit;

  // --------------------
  // routers
  // --------------------

  for (genvar i = 0; i < p_num_nodes; i++)
  begin : g_node
    // upstream neighbor, wraps at node 0
    localparam int c_prev = (i + p_num_nodes - 1) % p_num_nodes;

    ring_router #(
      .p_num_nodes   (p_num_nodes),
      .p_queue_depth (p_queue_depth)
    ) u_router (
      .clk             (clk),
      .reset           (reset),
      .node_id         (node_id_t'(i)),
      .in_val          (in_val[i]),
      .in_msg          (in_msg[i]),
      .in_credit       (in_credit[i]),
      .link_in_val     (link_val[c_prev]),
      .link_in_msg     (link_msg[c_prev]),
      .link_in_credit  (link_credit[c_prev]),
      .link_out_val    (link_val[i]),
      .link_out_msg    (link_msg[i]),
      .link_out_credit (link_credit[i]),
      .out_val         (out_val[i]),
      .out_msg         (out_msg[i]),
      .out_credit      (out_credit[i])
    );
  end

endmodule

// ==== ring_pkg.sv ====
// message field types, message type and width constants for the ring network
// plus the state encoding of the clockwise output arbiter

package ring_pkg;

  // --------------------
  // field widths
  // --------------------

  localparam int C_NODE_NBITS    = 3;
  localparam int C_OPAQUE_NBITS  = 8;
  localparam int C_PAYLOAD_NBITS = 8;
  localparam int C_CREDIT_NBITS  = 3;

  // dest, src, opaque, payload from the top bit down
  localparam int C_MSG_NBITS = 2 * C_NODE_NBITS + C_OPAQUE_NBITS + C_PAYLOAD_NBITS;

  // lsb position of each field
  localparam int C_PAYLOAD_LSB = 0;
  localparam int C_OPAQUE_LSB  = C_PAYLOAD_LSB + C_PAYLOAD_NBITS;
  localparam int C_SRC_LSB     = C_OPAQUE_LSB + C_OPAQUE_NBITS;
  localparam int C_DEST_LSB    = C_SRC_LSB + C_NODE_NBITS;

  // --------------------
  // types
  // --------------------

  typedef logic [C_NODE_NBITS-1:0]    node_id_t;
  typedef logic [C_OPAQUE_NBITS-1:0]  opaque_t;
  typedef logic [C_PAYLOAD_NBITS-1:0] payload_t;
  typedef logic [C_MSG_NBITS-1:0]     net_msg_t;

  // free slots downstream, depths up to 7
  typedef logic [C_CREDIT_NBITS-1:0]  credit_cnt_t;

  // requester granted most recently
  typedef enum logic {
    last_ring,
    last_inject
  } arb_state_t;

  // destination field of a message
  function automatic node_id_t msg_dest(input net_msg_t msg);
    return msg[C_DEST_LSB +: C_NODE_NBITS];
  endfunction

endpackage

// ==== ring_router.sv ====
// one ring node: injection and ring input queues, local/clockwise routing,
// ejection and clockwise arbitration, credit counters and output registers

module ring_router
#(
  parameter int p_num_nodes   = 8,
  parameter int p_queue_depth = 4
)
(
  input  logic               clk,
  input  logic               reset,
  input  ring_pkg::node_id_t node_id,
  // injection port
  input  logic               in_val,
  input  ring_pkg::net_msg_t in_msg,
  output logic               in_credit,
  // ring input from the upstream router
  input  logic               link_in_val,
  input  ring_pkg::net_msg_t link_in_msg,
  output logic               link_in_credit,
  // ring output to the downstream router
  output logic               link_out_val,
  output ring_pkg::net_msg_t link_out_msg,
  input  logic               link_out_credit,
  // ejection port
  output logic               out_val,
  output ring_pkg::net_msg_t out_msg,
  input  logic               out_credit
);

  import ring_pkg::*;

  // queue heads
  logic        inj_head_val;
  net_msg_t    inj_head_msg;
  logic        inj_pop;
  logic        ring_head_val;
  net_msg_t    ring_head_msg;
  logic        ring_pop;

  // routing decisions
  logic        inj_local;
  logic        ring_local;

  // ejection side
  credit_cnt_t eject_credit;
  logic        eject_prio;
  logic        ring_ej_gnt;
  logic        inj_ej_gnt;
  logic        ej_send;
  net_msg_t    ej_msg;

  // clockwise side
  credit_cnt_t cw_credit;
  logic        ring_cw_gnt;
  logic        inj_cw_gnt;
  logic        cw_send;
  net_msg_t    cw_msg;

  // --------------------
  // input queues
  // --------------------

  ring_msg_queue #(
    .p_queue_depth (p_queue_depth)
  ) u_inj_q (
    .clk      (clk),
    .reset    (reset),
    .push     (in_val),
    .push_msg (in_msg),
    .pop      (inj_pop),
    .head_val (inj_head_val),
    .head_msg (inj_head_msg),
    .credit   (in_credit)
  );

  ring_msg_queue #(
    .p_queue_depth (p_queue_depth)
  ) u_ring_q (
    .clk      (clk),
    .reset    (reset),
    .push     (link_in_val),
    .push_msg (link_in_msg),
    .pop      (ring_pop),
    .head_val (ring_head_val),
    .head_msg (ring_head_msg),
    .credit   (link_in_credit)
  );

  // --------------------
  // routing
  // --------------------

  // own id means eject, anything else keeps going clockwise
  assign inj_local  = inj_head_val && (msg_dest(inj_head_msg) == node_id);
  assign ring_local = ring_head_val && (msg_dest(ring_head_msg) == node_id);

  // ejection: one sink credit needed, priority bit breaks ties
  // eject_prio low favors the ring head
  assign ring_ej_gnt = (eject_credit != '0) && ring_local && (!inj_local || !eject_prio);
  assign inj_ej_gnt  = (eject_credit != '0) && inj_local && (!ring_local || eject_prio);
  assign ej_send     = ring_ej_gnt || inj_ej_gnt;
  assign ej_msg      = ring_ej_gnt ? ring_head_msg : inj_head_msg;

  // clockwise: bubble rule handled in the arbiter
  ring_arbiter u_cw_arb (
    .clk         (clk),
    .reset       (reset),
    .ring_req    (ring_head_val && !ring_local),
    .inject_req  (inj_head_val && !inj_local),
    .ring_credit (cw_credit),
    .ring_gnt    (ring_cw_gnt),
    .inject_gnt  (inj_cw_gnt)
  );

  assign cw_send = ring_cw_gnt || inj_cw_gnt;
  assign cw_msg  = ring_cw_gnt ? ring_head_msg : inj_head_msg;

  // a head leaves its queue on either grant
  assign ring_pop = ring_ej_gnt || ring_cw_gnt;
  assign inj_pop  = inj_ej_gnt || inj_cw_gnt;

  // --------------------
  // credits and state
  // --------------------

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      eject_credit <= credit_cnt_t'(p_queue_depth);
      cw_credit    <= credit_cnt_t'(p_queue_depth);
      eject_prio   <= 1'b0;
    end
    else
    begin
      eject_credit <= eject_credit + credit_cnt_t'(out_credit) - credit_cnt_t'(ej_send);
      cw_credit    <= cw_credit + credit_cnt_t'(link_out_credit) - credit_cnt_t'(cw_send);
      // flip toward the other requester after a grant
      if (ring_ej_gnt)
        eject_prio <= 1'b1;
      else if (inj_ej_gnt)
        eject_prio <= 1'b0;
    end
  end

  // --------------------
  // output registers
  // --------------------

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      out_val      <= 1'b0;
      link_out_val <= 1'b0;
    end
    else
    begin
      out_val      <= ej_send;
      link_out_val <= cw_send;
    end
  end

  // message registers load only when something is sent
  always_ff @(posedge clk)
  begin
    if (ej_send)
      out_msg <= ej_msg;
    if (cw_send)
      link_out_msg <= cw_msg;
  end

  // credits come back from the sink and the downstream queue
  a_credit_bound: assert property (@(posedge clk) disable iff (reset)
    (eject_credit <= credit_cnt_t'(p_queue_depth)) &&
    (cw_credit <= credit_cnt_t'(p_queue_depth)));

  // a message on the ring with no matching node would circle forever
  a_dest_in_range: assert property (@(posedge clk) disable iff (reset)
    ring_head_val |-> (int'(msg_dest(ring_head_msg)) < p_num_nodes) &&
                      (int'(node_id) < p_num_nodes));

endmodule

// ==== ring_tb.sv ====
// testbench top for the ring network: clock, reset, trace reader,
// source and sink credit models, watchdog and closing report

module ring_tb;

  import ring_pkg::*;

  localparam int    c_num_nodes   = 8;
  localparam int    c_queue_depth = 4;
  localparam int    c_period      = 20;
  localparam int    c_max_msgs    = 64;
  localparam int    c_seed        = 32'h8c42;
  localparam string c_trace_file  = "ring_trace.txt";

  logic                                 clk;
  logic                                 reset      = 1'b1;
  logic [c_num_nodes-1:0]               in_val     = '0;
  ring_pkg::net_msg_t [c_num_nodes-1:0] in_msg     = '0;
  logic [c_num_nodes-1:0]               in_credit;
  logic [c_num_nodes-1:0]               out_val;
  ring_pkg::net_msg_t [c_num_nodes-1:0] out_msg;
  logic [c_num_nodes-1:0]               out_credit = '0;

  // six hex words per trace line
  logic [7:0] trace_mem [6*c_max_msgs];
  net_msg_t   src_q [c_num_nodes][$];
  int         src_cr [c_num_nodes];
  int         sink_cr [c_num_nodes];
  int         sink_owed [c_num_nodes];
  logic [c_num_nodes-1:0] sink_empty = '0;
  int         seed;
  int         stall = 0;
  int         num_msgs = 0;
  int         max_stall = 0;
  logic       trace_loaded = 1'b0;
  logic       inject_started = 1'b0;
  logic       end_of_test = 1'b0;
  int         error_count;
  int         pending;
  int         delivered;

  ring_net #(
    .p_num_nodes   (c_num_nodes),
    .p_queue_depth (c_queue_depth)
  ) u_dut (
    .clk        (clk),
    .reset      (reset),
    .in_val     (in_val),
    .in_msg     (in_msg),
    .in_credit  (in_credit),
    .out_val    (out_val),
    .out_msg    (out_msg),
    .out_credit (out_credit)
  );

  ring_checker #(
    .p_num_nodes   (c_num_nodes),
    .p_queue_depth (c_queue_depth)
  ) u_chk (
    .clk            (clk),
    .reset          (reset),
    .inject_started (inject_started),
    .end_of_test    (end_of_test),
    .in_val         (in_val),
    .in_msg         (in_msg),
    .in_credit      (in_credit),
    .out_val        (out_val),
    .out_msg        (out_msg),
    .sink_empty     (sink_empty),
    .error_count    (error_count),
    .pending        (pending),
    .delivered      (delivered)
  );

  initial
  begin
    clk = 1'b0;
    forever #(c_period / 2) clk = ~clk;
  end

  // 0..99, advances the seed
  function automatic int roll_percent();
    return ($random(seed) & 32'h7fffffff) % 100;
  endfunction

  // dest, src, opaque, payload from trace line idx
  function automatic net_msg_t build_msg(input int idx);
    return {trace_mem[6*idx+2][2:0], trace_mem[6*idx+1][2:0],
            trace_mem[6*idx+3], trace_mem[6*idx+4]};
  endfunction

  function automatic bit sources_idle();
    for (int i = 0; i < c_num_nodes; i++)
      if (src_q[i].size() != 0)
        return 1'b0;
    return 1'b1;
  endfunction

  // --------------------
  // source and sink models
  // --------------------

  always @(posedge clk)
  begin
    for (int i = 0; i < c_num_nodes; i++)
    begin
      in_val[i]     <= 1'b0;
      out_credit[i] <= 1'b0;
      if (reset)
      begin
        src_cr[i]    = c_queue_depth;
        sink_cr[i]   = c_queue_depth;
        sink_owed[i] = 0;
      end
      else
      begin
        // credit traffic seen at this edge
        src_cr[i]    = src_cr[i] + int'(in_credit[i]);
        sink_cr[i]   = sink_cr[i] + int'(out_credit[i]) - int'(out_val[i]);
        sink_owed[i] = sink_owed[i] + int'(out_val[i]);
        // sink hands a credit back with random delay
        if (sink_owed[i] > 0 && roll_percent() >= stall)
        begin
          out_credit[i] <= 1'b1;
          sink_owed[i]  = sink_owed[i] - 1;
        end
        // source stalls half as often as the sink
        if (src_q[i].size() != 0 && src_cr[i] > 0 && roll_percent() >= stall / 2)
        begin
          in_val[i]      <= 1'b1;
          in_msg[i]      <= src_q[i].pop_front();
          src_cr[i]      = src_cr[i] - 1;
          inject_started <= 1'b1;
        end
      end
      sink_empty[i] <= (sink_cr[i] == 0);
    end
  end

  // --------------------
  // main sequence
  // --------------------

  initial
  begin
    int n;
    int cur_test;
    seed = c_seed;
    $readmemh(c_trace_file, trace_mem);
    while (num_msgs < c_max_msgs && trace_mem[6*num_msgs] != 8'hff)
    begin
      if (int'(trace_mem[6*num_msgs+5]) > max_stall)
        max_stall = int'(trace_mem[6*num_msgs+5]);
      num_msgs++;
    end
    trace_loaded = 1'b1;
    repeat (5) @(posedge clk);
    reset <= 1'b0;
    // idle window for the post-reset check
    repeat (10) @(posedge clk);
    n = 0;
    while (n < num_msgs)
    begin
      cur_test = int'(trace_mem[6*n]);
      @(negedge clk);
      stall = int'(trace_mem[6*n+5]);
      while (n < num_msgs && int'(trace_mem[6*n]) == cur_test)
      begin
        src_q[trace_mem[6*n+1][2:0]].push_back(build_msg(n));
        n++;
      end
      // let the test drain before the next one
      do
        @(negedge clk);
      while (!sources_idle());
      repeat (3) @(negedge clk);
      while (pending != 0)
        @(negedge clk);
      $display("test %0d drained", cur_test);
    end
    @(posedge clk);
    end_of_test <= 1'b1;
    @(posedge clk);
    end_of_test <= 1'b0;
    repeat (2) @(negedge clk);
    $display("errors: %0d, delivered %0d of %0d", error_count, delivered, num_msgs);
    if (error_count == 0 && delivered == num_msgs)
      $display("RESULT: PASS");
    else
      $display("RESULT: FAIL");
    $finish;
  end

  // watchdog, scaled by trace length and worst stall
  initial
  begin
    longint limit;
    wait (trace_loaded);
    limit = longint'(num_msgs * 2 * c_num_nodes + 200) * c_period * (1 + max_stall);
    #(limit);
    $display("watchdog: run did not finish within %0d time units", limit);
    $display("errors: %0d, delivered %0d of %0d", error_count, delivered, num_msgs);
    $display("RESULT: FAIL");
    $finish;
  end

endmodule

// ==== ring_trace.txt ====
// columns: test src dest opaque payload sink_stall_percent, all hex
// 01 sweep from node 0, 02 hot spot on node 3, 03 neighbor streams, 04 random pairs, ff ends
01 0 0 10 a0 00
01 0 1 11 a1 00
01 0 2 12 a2 00
01 0 3 13 a3 00
01 0 4 14 a4 00
01 0 5 15 a5 00
01 0 6 16 a6 00
01 0 7 17 a7 00
02 0 3 20 b0 5a
02 1 3 21 b1 5a
02 2 3 22 b2 5a
02 3 3 23 b3 5a
02 4 3 24 b4 5a
02 5 3 25 b5 5a
02 6 3 26 b6 5a
02 7 3 27 b7 5a
03 1 2 30 c0 14
03 1 2 31 c1 14
03 1 2 32 c2 14
03 6 7 33 c3 14
03 7 0 34 c4 14
03 7 0 35 c5 14
04 4 1 40 d0 32
04 2 6 41 d1 32
04 7 5 42 d2 32
04 4 1 43 d3 32
04 0 4 44 d4 32
04 5 2 45 d5 32
ff 0 0 00 00 00

// ==== run_sim.sh ====
#!/bin/sh
# build the ring network testbench with Verilator, run it, check the log

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module ring_tb -f files.f -o sim_ring
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/sim_ring > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "RESULT: FAIL" "$LOG"; then
  exit 1
fi
exit 0
